// File: bench/msau_model.svh
// SIMD result stage reference model

`ifndef MSAU_MODEL_SVH
`define MSAU_MODEL_SVH

function automatic value_t elem_mask(int unsigned ew);
	return (ew >= DATA_W) ? '1 : ((value_t'(1) << ew) - 1);
endfunction

// Both elements are right-aligned and already cut to ew bits
function automatic value_t combine_elems(func_e fn, value_t x, value_t y, int unsigned ew);
	value_t bias;
	value_t r;
	// Flipping the sign bits lets an unsigned compare order signed values
	bias = value_t'(1) << (ew - 1);
	case (fn)
		FN_ADD:  r = x + y;
		FN_SUB:  r = x - y;
		FN_AND:  r = x & y;
		FN_OR:   r = x | y;
		FN_XOR:  r = x ^ y;
		FN_MAXU: r = (x > y) ? x : y;
		FN_MINU: r = (x < y) ? x : y;
		FN_MAX:  r = ((x ^ bias) > (y ^ bias)) ? x : y;
		FN_MIN:  r = ((x ^ bias) < (y ^ bias)) ? x : y;
		default: r = '0;
	endcase
	return r & elem_mask(ew);
endfunction

function automatic value_t lane_result(msau_req_t req);
	int unsigned ew;
	value_t      m;
	value_t      r;
	ew = 8 << req.elem;
	m = elem_mask(ew);
	r = '0;
	for (int i = 0; i < DATA_W / ew; i++)
		r |= combine_elems(req.func, (req.a >> (i * ew)) & m,
			(req.b >> (i * ew)) & m, ew) << (i * ew);
	return r;
endfunction

// Disabled elements would only fold in the identity, so they are skipped
function automatic value_t reduce_result(msau_req_t req);
	int unsigned ew;
	value_t      m;
	value_t      acc;
	ew = 8 << req.elem;
	m = elem_mask(ew);
	if (req.func == FN_SUB)
		return '0;
	acc = req.b & m;
	for (int k = 0; k < DATA_W / ew; k++)
		if (req.c[k])
			acc = combine_elems(req.func, acc, (req.a >> (k * ew)) & m, ew);
	return acc;
endfunction

function automatic value_t computed_result(msau_req_t req);
	if (!req.valid)
		return '0;
	case (req.opclass)
		OPC_LANE: return lane_result(req);
		OPC_RED:  return reduce_result(req);
		default:  return '0;
	endcase
endfunction

function automatic value_t merge_bytes(value_t v, value_t t, byte_mask_t cptgt,
	logic zero, logic stomp);
	value_t r;
	for (int j = 0; j < DATA_W / 8; j++) begin
		if (stomp)
			r[j*8 +: 8] = t[j*8 +: 8];
		else if (cptgt[j])
			r[j*8 +: 8] = zero ? 8'h00 : t[j*8 +: 8];
		else
			r[j*8 +: 8] = v[j*8 +: 8];
	end
	return r;
endfunction

function automatic we_mask_t write_enable(msau_req_t req, int unsigned base);
	if (!req.valid)
		return '0;
	if (int'(req.rd) >= base && int'(req.rd) < base + 8) begin
		case (req.mode)
			OM_APP:        return 9'h001;
			OM_SUPERVISOR: return 9'h003;
			OM_HYPERVISOR: return 9'h007;
			default:       return 9'h1FF;
		endcase
	end
	return (req.rd != '0) ? 9'h1FF : 9'h000;
endfunction

`endif

// File: bench/msau_tb.sv
// SIMD result stage testbench

`timescale 1ns/100ps

module msau_tb;

	import msau_pkg::*;

	`include "msau_model.svh"

	localparam int unsigned REG_BLOCK_BASE = 56;
	localparam int N_PER_PHASE = 300;
	localparam int WAIT_LIMIT = 50;

	logic       clk;
	logic       arst_n_i;
	msau_req_t  req_i;
	byte_mask_t cptgt_i;
	logic       zero_i;
	logic       stomp_i;
	msau_rsp_t  rsp_o;

	integer    seed = 32'hb4a0;
	msau_rsp_t exp_q [$];

	msau_top #(
		.REG_BLOCK_BASE (REG_BLOCK_BASE)
	) UUT (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req_i),
		.cptgt_i  (cptgt_i),
		.zero_i   (zero_i),
		.stomp_i  (stomp_i),
		.rsp_o    (rsp_o)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	initial begin
		arst_n_i = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		arst_n_i = 1'b1;
	end

	// ==============================
	// Checks
	// ==============================

	task automatic fail_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(string name, value_t exp, value_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h, got %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_we(string name, we_mask_t exp, we_mask_t act);
		if (act !== exp) begin
			$display("** Error: %s expected %h, got %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_valid(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("** Error: %s expected %h, got %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic compare_response(msau_rsp_t exp);
		check_valid("rsp_o.valid", exp.valid, rsp_o.valid);
		check_we("rsp_o.we", exp.we, rsp_o.we);
		check_value("rsp_o.value", exp.value, rsp_o.value);
	endtask

	// ==============================
	// Stimulus
	// ==============================

	function automatic int unsigned rand_below(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Register numbers lean toward zero and the block around 56
	function automatic areg_t pick_rd();
		case (rand_below(4))
			0:       return '0;
			1:       return areg_t'(REG_BLOCK_BASE + rand_below(8));
			2:       return areg_t'(REG_BLOCK_BASE - 8 + rand_below(24));
			default: return areg_t'(rand_below(256));
		endcase
	endfunction

	// Phase 0 idles, 1 lanes, 2 reductions, 3 merge, 4 write-enable
	task automatic make_stimulus(int phase);
		req_i.valid   = 1'b1;
		req_i.opclass = opclass_e'(rand_below(3));
		req_i.func    = func_e'(rand_below(9));
		req_i.elem    = elem_e'(rand_below(4));
		req_i.mode    = mode_e'(rand_below(4));
		req_i.rd      = pick_rd();
		req_i.a       = {$random(seed), $random(seed)};
		req_i.b       = {$random(seed), $random(seed)};
		req_i.c       = {$random(seed), $random(seed)};
		req_i.t       = {$random(seed), $random(seed)};
		cptgt_i       = '0;
		zero_i        = 1'b0;
		stomp_i       = 1'b0;
		if (phase == 1)
			req_i.opclass = OPC_LANE;
		if (phase == 2)
			req_i.opclass = OPC_RED;
		if (phase == 0)
			req_i.valid = 1'b0;
		if (phase == 4)
			req_i.valid = rand_below(2);
		if (phase == 0 || phase == 3) begin
			cptgt_i = byte_mask_t'(rand_below(256));
			zero_i  = rand_below(2);
			stomp_i = (rand_below(4) == 0);
		end
	endtask

	// Called just after a rising edge, when the last response is stable
	task automatic run_cycle(int phase);
		msau_rsp_t exp;
		if (exp_q.size() != 0)
			compare_response(exp_q.pop_front());
		make_stimulus(phase);
		exp.valid = req_i.valid;
		exp.we    = write_enable(req_i, REG_BLOCK_BASE);
		exp.value = merge_bytes(computed_result(req_i), req_i.t, cptgt_i, zero_i, stomp_i);
		exp_q.push_back(exp);
		@(posedge clk);
		#1;
	endtask

	initial begin : main
		int cycles;
		// A valid request held during reset must leave the response at zero
		make_stimulus(3);
		@(posedge clk);
		#1;
		check_valid("rsp_o.valid", 1'b0, rsp_o.valid);
		check_we("rsp_o.we", '0, rsp_o.we);
		check_value("rsp_o.value", '0, rsp_o.value);

		req_i   = '0;
		cptgt_i = '0;
		zero_i  = 1'b0;
		stomp_i = 1'b0;

		cycles = 0;
		while (arst_n_i !== 1'b1) begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Error: reset still asserted after %0d cycles", WAIT_LIMIT);
				fail_run();
			end
		end
		#1;
		check_valid("rsp_o.valid", 1'b0, rsp_o.valid);
		check_we("rsp_o.we", '0, rsp_o.we);
		check_value("rsp_o.value", '0, rsp_o.value);

		for (int phase = 0; phase < 5; phase++)
			repeat (N_PER_PHASE) run_cycle(phase);

		req_i   = '0;
		cptgt_i = '0;
		zero_i  = 1'b0;
		stomp_i = 1'b0;
		cycles  = 0;
		while (exp_q.size() != 0) begin
			compare_response(exp_q.pop_front());
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Error: responses still pending after %0d cycles", WAIT_LIMIT);
				fail_run();
			end
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: list.f
+incdir+bench
src/msau_pkg.sv
src/msau_ctrl.sv
src/msau_lane_alu.sv
src/msau_reduce.sv
src/msau_merge.sv
src/msau_top.sv
bench/msau_tb.sv

// File: src/msau_ctrl.sv
// SIMD result stage control
// Path select and write-enable

`timescale 1ns/100ps

module msau_ctrl #(
	parameter int unsigned REG_BLOCK_BASE = 56
) (
	input  logic                clk,
	input  logic                arst_n_i,
	input  msau_pkg::msau_req_t req_i,
	output logic                sel_red_o,
	output logic                valid_o,
	output msau_pkg::we_mask_t  we_o
);

	import msau_pkg::*;

	logic     in_block;
	we_mask_t we_d;

	// Only the reduction class takes the folded result
	always_comb begin
		sel_red_o = (req_i.opclass == OPC_RED);
	end

	// ==============================
	// Write-enable decode
	// ==============================

	always_comb begin
		in_block = (req_i.rd >= REG_BLOCK_BASE) && (req_i.rd < REG_BLOCK_BASE + 8);

		if (!req_i.valid) begin
			we_d = '0;
		end else if (in_block) begin
			// The register block opens up wider with the privilege of the mode
			case (req_i.mode)
				OM_APP:        we_d = 9'h001;
				OM_SUPERVISOR: we_d = 9'h003;
				OM_HYPERVISOR: we_d = 9'h007;
				default:       we_d = 9'h1FF;
			endcase
		end else if (req_i.rd != '0) begin
			we_d = 9'h1FF;
		end else begin
			// Register zero is never written
			we_d = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
			we_o    <= '0;
		end else begin
			valid_o <= req_i.valid;
			we_o    <= we_d;
		end
	end

	// ==============================
	// Checks
	// ==============================

	we_needs_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
		(we_o != '0) |-> valid_o)
		else $error("write-enable raised without a valid response");

	func_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
		req_i.valid |-> (req_i.func <= FN_MIN))
		else $error("valid request with undefined function code %0h", req_i.func);

endmodule

// File: src/msau_lane_alu.sv
// SIMD element-wise integer ALU

`timescale 1ns/100ps

module msau_lane_alu (
	input  msau_pkg::msau_req_t req_i,
	output msau_pkg::value_t    lane_o
);

	import msau_pkg::*;

	// One full-width result per element size
	value_t size_res [4];

	// ==============================
	// Per-element datapath
	// ==============================

	for (genvar s = 0; s < 4; s++) begin : g_size
		localparam int EW = 8 << s;

		for (genvar e = 0; e < DATA_W / EW; e++) begin : g_elem
			logic [EW-1:0] ea;
			logic [EW-1:0] eb;
			logic [EW-1:0] eo;
			logic          lt_u;
			logic          lt_s;

			assign ea = req_i.a[e*EW +: EW];
			assign eb = req_i.b[e*EW +: EW];

			// Both compares feed the max and min pairs
			assign lt_u = ea < eb;
			assign lt_s = $signed(ea) < $signed(eb);

			always_comb begin
				case (req_i.func)
					FN_ADD:  eo = ea + eb;
					FN_SUB:  eo = ea - eb;
					FN_AND:  eo = ea & eb;
					FN_OR:   eo = ea | eb;
					FN_XOR:  eo = ea ^ eb;
					FN_MAXU: eo = lt_u ? eb : ea;
					FN_MINU: eo = lt_u ? ea : eb;
					FN_MAX:  eo = lt_s ? eb : ea;
					FN_MIN:  eo = lt_s ? ea : eb;
					default: eo = '0;
				endcase
			end

			assign size_res[s][e*EW +: EW] = eo;
		end
	end

	// ==============================
	// Size select
	// ==============================

	always_comb begin
		if (req_i.opclass != OPC_LANE) begin
			lane_o = '0;
		end else begin
			case (req_i.elem)
				ELEM_B:  lane_o = size_res[0];
				ELEM_W:  lane_o = size_res[1];
				ELEM_T:  lane_o = size_res[2];
				default: lane_o = size_res[3];
			endcase
		end
	end

endmodule

// File: src/msau_merge.sv
// SIMD result merge with target

`timescale 1ns/100ps

module msau_merge (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 valid_i,
	input  logic                 sel_red_i,
	input  msau_pkg::value_t     lane_i,
	input  msau_pkg::value_t     red_i,
	input  msau_pkg::value_t     t_i,
	input  msau_pkg::byte_mask_t cptgt_i,
	input  logic                 zero_i,
	input  logic                 stomp_i,
	output msau_pkg::value_t     value_o
);

	import msau_pkg::*;

	value_t pick;
	value_t merged;

	// An idle cycle computes nothing
	always_comb begin
		if (!valid_i)
			pick = '0;
		else if (sel_red_i)
			pick = red_i;
		else
			pick = lane_i;
	end

	// ==============================
	// Bytewise merge
	// ==============================

	// Stomp wins over the checkpoint mask
	for (genvar j = 0; j < DATA_W / 8; j++) begin : g_byte
		assign merged[j*8 +: 8] = stomp_i    ? t_i[j*8 +: 8] :
		                          cptgt_i[j] ? (zero_i ? 8'h00 : t_i[j*8 +: 8]) :
		                                       pick[j*8 +: 8];
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			value_o <= '0;
		else
			value_o <= merged;
	end

	stomp_keeps_t: assert property (@(posedge clk) disable iff (!arst_n_i)
		stomp_i |=> (value_o == $past(t_i)))
		else $error("stomped result %h differs from target", value_o);

endmodule

// File: src/msau_pkg.sv
// SIMD result stage
// Shared types and constants

package msau_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int DATA_W = 64;

	typedef logic [DATA_W-1:0]   value_t;
	typedef logic [DATA_W/8-1:0] byte_mask_t;
	// Eight byte enables with the tag enable on top
	typedef logic [DATA_W/8:0]   we_mask_t;
	typedef logic [7:0]          areg_t;

	// ==============================
	// Encodings
	// ==============================

	typedef enum logic [1:0] {
		ELEM_B,
		ELEM_W,
		ELEM_T,
		ELEM_O
	} elem_e;

	typedef enum logic [1:0] {
		OPC_LANE,
		OPC_RED,
		OPC_NOP
	} opclass_e;

	// Reductions reuse the same codes, FN_ADD being the sum
	typedef enum logic [3:0] {
		FN_ADD,
		FN_SUB,
		FN_AND,
		FN_OR,
		FN_XOR,
		FN_MAXU,
		FN_MINU,
		FN_MAX,
		FN_MIN
	} func_e;

	typedef enum logic [1:0] {
		OM_APP,
		OM_SUPERVISOR,
		OM_HYPERVISOR,
		OM_SECURE
	} mode_e;

	// ==============================
	// Request and response
	// ==============================

	typedef struct packed {
		logic     valid;
		opclass_e opclass;
		func_e    func;
		elem_e    elem;
		mode_e    mode;
		areg_t    rd;
		value_t   a;
		value_t   b;
		value_t   c;
		value_t   t;
	} msau_req_t;

	typedef struct packed {
		logic     valid;
		value_t   value;
		we_mask_t we;
	} msau_rsp_t;

endpackage

// File: src/msau_reduce.sv
// SIMD masked reduction

`timescale 1ns/100ps

module msau_reduce (
	input  msau_pkg::msau_req_t req_i,
	output msau_pkg::value_t    red_o
);

	import msau_pkg::*;

	// Elements travel at full width, zero- or sign-extended, and are cut back at the end

	function automatic value_t width_mask(int unsigned ew);
		return {DATA_W{1'b1}} >> (DATA_W - ew);
	endfunction

	function automatic value_t extend(value_t v, int unsigned ew, logic sgn);
		value_t m;
		m = width_mask(ew);
		if (sgn && v[ew-1])
			return v | ~m;
		return v & m;
	endfunction

	// Value that leaves the fold unchanged, already extended
	function automatic value_t identity(func_e fn, int unsigned ew);
		value_t m;
		m = width_mask(ew);
		case (fn)
			FN_AND, FN_MINU: return m;
			FN_MAX:          return ~(m >> 1);
			FN_MIN:          return m >> 1;
			default:         return '0;
		endcase
	endfunction

	function automatic value_t fold2(func_e fn, value_t x, value_t y);
		case (fn)
			FN_ADD:  return x + y;
			FN_AND:  return x & y;
			FN_OR:   return x | y;
			FN_XOR:  return x ^ y;
			FN_MAXU: return (x > y) ? x : y;
			FN_MINU: return (x < y) ? x : y;
			FN_MAX:  return ($signed(x) > $signed(y)) ? x : y;
			FN_MIN:  return ($signed(x) < $signed(y)) ? x : y;
			default: return '0;
		endcase
	endfunction

	logic   sgn;
	value_t size_res [4];

	assign sgn = (req_i.func == FN_MAX) || (req_i.func == FN_MIN);

	// ==============================
	// Fold tree per element size
	// ==============================

	for (genvar s = 0; s < 4; s++) begin : g_size
		localparam int EW = 8 << s;
		localparam int N = DATA_W / EW;

		// Heap order, leaves sit at N-1 and up
		value_t node [2*N-1];
		value_t b0;

		for (genvar k = 0; k < N; k++) begin : g_leaf
			assign node[N-1+k] = req_i.c[k] ?
				extend(value_t'(req_i.a[k*EW +: EW]), EW, sgn) :
				identity(req_i.func, EW);
		end

		for (genvar i = 0; i < N - 1; i++) begin : g_node
			assign node[i] = fold2(req_i.func, node[2*i+1], node[2*i+2]);
		end

		assign b0 = extend(value_t'(req_i.b[EW-1:0]), EW, sgn);
		assign size_res[s] = fold2(req_i.func, node[0], b0) & width_mask(EW);
	end

	always_comb begin
		case (req_i.elem)
			ELEM_B:  red_o = size_res[0];
			ELEM_W:  red_o = size_res[1];
			ELEM_T:  red_o = size_res[2];
			default: red_o = size_res[3];
		endcase
	end

	// There is no subtract reduction, so its slot in the result stays empty
	sub_red_zero: assert final (!(req_i.valid && req_i.opclass == OPC_RED &&
		req_i.func == FN_SUB) || red_o == '0)
		else $error("subtract reduction produced %h", red_o);

endmodule

// File: src/msau_top.sv
// SIMD result stage top level

`timescale 1ns/100ps

module msau_top #(
	parameter int unsigned REG_BLOCK_BASE = 56
) (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  msau_pkg::msau_req_t  req_i,
	input  msau_pkg::byte_mask_t cptgt_i,
	input  logic                 zero_i,
	input  logic                 stomp_i,
	output msau_pkg::msau_rsp_t  rsp_o
);

	import msau_pkg::*;

	logic     sel_red;
	logic     valid;
	we_mask_t we;
	value_t   lane;
	value_t   red;
	value_t   value;

	// ==============================
	// Control
	// ==============================

	msau_ctrl #(
		.REG_BLOCK_BASE (REG_BLOCK_BASE)
	) u_ctrl (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.req_i     (req_i),
		.sel_red_o (sel_red),
		.valid_o   (valid),
		.we_o      (we)
	);

	// ==============================
	// Datapath
	// ==============================

	msau_lane_alu u_lane_alu (
		.req_i  (req_i),
		.lane_o (lane)
	);

	msau_reduce u_reduce (
		.req_i (req_i),
		.red_o (red)
	);

	msau_merge u_merge (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.valid_i   (req_i.valid),
		.sel_red_i (sel_red),
		.lane_i    (lane),
		.red_i     (red),
		.t_i       (req_i.t),
		.cptgt_i   (cptgt_i),
		.zero_i    (zero_i),
		.stomp_i   (stomp_i),
		.value_o   (value)
	);

	assign rsp_o = '{valid: valid, value: value, we: we};

endmodule
